//--- source/errdp_pkg.sv
// shared widths for the fetch error datapath
// select codes for error address, ASI source, error and misc reads
// error address word, read as a plain address or as an IRF record

package errdp_pkg;

   // ---------------------------------------------------------------------------
   // widths
   // ---------------------------------------------------------------------------
   localparam int IC_TAG_W   = 28;
   localparam int IC_WAY_W   = IC_TAG_W + 1;
   localparam int IC_WAYS    = 4;
   localparam int INST_W     = 34;
   localparam int EADDR_W    = 44;
   localparam int PC_W       = 48;
   localparam int ASI_W      = 64;
   localparam int IMASK_W    = 39;
   localparam int IRF_W      = 8;
   localparam int EADR_SEL_W = 3;

   // diagnostic read fields and select widths
   localparam int TAG_RD_W   = 32;
   localparam int ERREN_W    = 2;
   localparam int ERRSTAT_W  = 23;
   localparam int ERRINJ_W   = 32;
   localparam int SEL_W      = 2;

   // ---------------------------------------------------------------------------
   // select codes
   // ---------------------------------------------------------------------------
   // per-thread error address source
   localparam logic [EADR_SEL_W-1:0] EADR_HOLD = 3'd0;
   localparam logic [EADR_SEL_W-1:0] EADR_IRF  = 3'd1;
   localparam logic [EADR_SEL_W-1:0] EADR_LSU  = 3'd2;
   localparam logic [EADR_SEL_W-1:0] EADR_PC   = 3'd3;
   localparam logic [EADR_SEL_W-1:0] EADR_ASI  = 3'd4;

   // final load data source
   localparam logic [SEL_W-1:0] ASI_SRC_ERR  = 2'd0;
   localparam logic [SEL_W-1:0] ASI_SRC_MISC = 2'd1;
   localparam logic [SEL_W-1:0] ASI_SRC_ICD  = 2'd2;
   localparam logic [SEL_W-1:0] ASI_SRC_ZERO = 2'd3;

   // error register read
   localparam logic [SEL_W-1:0] ERR_SEL_EN   = 2'd0;
   localparam logic [SEL_W-1:0] ERR_SEL_STAT = 2'd1;
   localparam logic [SEL_W-1:0] ERR_SEL_INJ  = 2'd2;
   localparam logic [SEL_W-1:0] ERR_SEL_ADDR = 2'd3;

   // misc read
   localparam logic [SEL_W-1:0] MISC_SEL_TAG   = 2'd0;
   localparam logic [SEL_W-1:0] MISC_SEL_IMASK = 2'd1;
   localparam logic [SEL_W-1:0] MISC_SEL_ZERO  = 2'd2;

   // IRF error record, packed into the low bits of an error address
   typedef struct packed {
      logic [23:0]      pad_hi;
      logic [IRF_W-1:0] synd;
      logic [3:0]       pad_lo;
      logic [IRF_W-1:0] regnum;
   } irf_rec_t;

   typedef union packed {
      logic [EADDR_W-1:0] addr;
      irf_rec_t           irf;
   } err_addr_u;

endpackage

//--- source/icache_parity_check.sv
// icache tag and valid staging
// per-way tag parity, fetch and next-instruction parity
// tag word for diagnostic reads of one way

`timescale 1ns/100ps

module icache_parity_check (
   input  logic                                                     rclk,
   input  logic                                                     arst_n,
   input  logic [errdp_pkg::IC_WAYS-1:0][errdp_pkg::IC_WAY_W-1:0]  ict_tags,
   input  logic [errdp_pkg::IC_WAYS-1:0]                            icv_valid,
   input  logic [errdp_pkg::INST_W-1:0]                             fetch_data,
   input  logic [errdp_pkg::INST_W-1:0]                             top_data,
   input  logic [errdp_pkg::SEL_W-1:0]                              asi_way,
   output logic [errdp_pkg::IC_WAYS-1:0]                            tag_pe,
   output logic                                                     fetch_pe,
   output logic                                                     nir_pe,
   output logic [errdp_pkg::TAG_RD_W-1:0]                           tag_asi_data
);

   logic [errdp_pkg::IC_WAYS-1:0][errdp_pkg::IC_WAY_W-1:0] tags_q;
   logic [errdp_pkg::IC_WAYS-1:0]                          valid_q;
   logic [errdp_pkg::IC_WAY_W-1:0]                         way_tag;

   // ---------------------------------------------------------------------------
   // tags
   // ---------------------------------------------------------------------------
   // tags land one cycle after the array read
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         tags_q  <= '0;
         valid_q <= '0;
      end else begin
         tags_q  <= ict_tags;
         valid_q <= icv_valid;
      end
   end

   // even parity over tag plus stored parity bit
   for (genvar w = 0; w < errdp_pkg::IC_WAYS; w++) begin : g_tag_par
      assign tag_pe[w] = ^tags_q[w];
   end

   // valid, 0, parity, 0, then the tag itself
   assign way_tag = tags_q[asi_way];
   assign tag_asi_data = {valid_q[asi_way],
                          1'b0,
                          way_tag[errdp_pkg::IC_TAG_W],
                          1'b0,
                          way_tag[errdp_pkg::IC_TAG_W-1:0]};

   // ---------------------------------------------------------------------------
   // instruction words
   // ---------------------------------------------------------------------------
   // checked in the same cycle as the words arrive
   assign fetch_pe = ^fetch_data;
   assign nir_pe   = ^top_data;

endmodule

//--- source/err_addr_capture.sv
// staging of IRF, LSU and fetch PC error sources
// per-thread error address registers with encoded source select
// error address read for the diagnostic ASI path

`timescale 1ns/100ps

module err_addr_capture #(
   parameter int NUM_THREADS = 4
) (
   input  logic                                                      rclk,
   input  logic                                                      arst_n,
   input  logic [errdp_pkg::IRF_W-1:0]                               irf_err_reg,
   input  logic [errdp_pkg::IRF_W-1:0]                               irf_err_synd,
   input  logic [errdp_pkg::EADDR_W-1:0]                             lsu_err_addr,
   input  logic [errdp_pkg::PC_W-1:0]                                fetch_pc,
   input  logic [errdp_pkg::PC_W-1:0]                                asi_wr_data,
   input  logic [NUM_THREADS-1:0][errdp_pkg::EADR_SEL_W-1:0]         eadr_sel,
   input  logic [errdp_pkg::SEL_W-1:0]                               asi_thread,
   output logic [errdp_pkg::EADDR_W-1:0]                             err_addr_read
);

   logic [errdp_pkg::IRF_W-1:0]   irf_reg_d;
   logic [errdp_pkg::IRF_W-1:0]   irf_reg_q;
   logic [errdp_pkg::IRF_W-1:0]   irf_synd_q;
   logic [errdp_pkg::EADDR_W-1:0] lsu_q;
   logic [errdp_pkg::EADDR_W-1:0] pc_s1;
   logic [errdp_pkg::EADDR_W-1:0] pc_d1;
   errdp_pkg::err_addr_u          irf_rec;
   logic [errdp_pkg::EADDR_W-1:0] eadr_q [NUM_THREADS];

   // ---------------------------------------------------------------------------
   // source staging
   // ---------------------------------------------------------------------------
   // register number bit 4 is corrected when bits 5 and 3 are both set
   assign irf_reg_d = {irf_err_reg[7:5],
                       irf_err_reg[4] ^ (irf_err_reg[5] & irf_err_reg[3]),
                       irf_err_reg[3:0]};

   // IRF and LSU sources, one stage
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         irf_reg_q  <= '0;
         irf_synd_q <= '0;
         lsu_q      <= '0;
      end else begin
         irf_reg_q  <= irf_reg_d;
         irf_synd_q <= irf_err_synd;
         lsu_q      <= lsu_err_addr;
      end
   end

   // fetch PC goes through two stages, only 47:4 is kept
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         pc_s1 <= '0;
         pc_d1 <= '0;
      end else begin
         pc_s1 <= fetch_pc[errdp_pkg::PC_W-1:4];
         pc_d1 <= pc_s1;
      end
   end

   // syndrome and register number in the low address bits
   always_comb begin
      irf_rec.irf.pad_hi = '0;
      irf_rec.irf.synd   = irf_synd_q;
      irf_rec.irf.pad_lo = '0;
      irf_rec.irf.regnum = irf_reg_q;
   end

   // ---------------------------------------------------------------------------
   // per-thread error address
   // ---------------------------------------------------------------------------
   for (genvar t = 0; t < NUM_THREADS; t++) begin : g_thr
      logic [errdp_pkg::EADDR_W-1:0] eadr_nxt;

      always_comb begin
         case (eadr_sel[t])
            errdp_pkg::EADR_IRF: eadr_nxt = irf_rec.addr;
            errdp_pkg::EADR_LSU: eadr_nxt = lsu_q;
            errdp_pkg::EADR_PC:  eadr_nxt = pc_d1;
            errdp_pkg::EADR_ASI: eadr_nxt = asi_wr_data[errdp_pkg::PC_W-1:4];
            // hold, and any unused code
            default:             eadr_nxt = eadr_q[t];
         endcase
      end

      always_ff @(posedge rclk or negedge arst_n) begin
         if (!arst_n) begin
            eadr_q[t] <= '0;
         end else begin
            eadr_q[t] <= eadr_nxt;
         end
      end
   end

   // thread select for the ASI read, out of range threads read zero
   always_comb begin
      err_addr_read = '0;
      for (int t = 0; t < NUM_THREADS; t++) begin
         if (int'(asi_thread) == t) begin
            err_addr_read = eadr_q[t];
         end
      end
   end

endmodule

//--- source/asi_read_path.sv
// instruction mask register
// error, misc and cache data word formatting for ASI loads
// registered load data to the LSU

`timescale 1ns/100ps

module asi_read_path #(
   parameter int NUM_THREADS = 4
) (
   input  logic                               rclk,
   input  logic                               arst_n,
   input  logic [errdp_pkg::PC_W-1:0]         asi_wr_data,
   input  logic                               ld_imask,
   input  logic [errdp_pkg::ERREN_W-1:0]      erren_data,
   input  logic [errdp_pkg::ERRSTAT_W-1:0]    errstat_data,
   input  logic [errdp_pkg::ERRINJ_W-1:0]     errinj_data,
   input  logic [errdp_pkg::EADDR_W-1:0]      err_addr_read,
   input  logic [errdp_pkg::TAG_RD_W-1:0]     tag_asi_data,
   input  logic [errdp_pkg::INST_W-1:0]       icd_asi_data,
   input  logic [errdp_pkg::SEL_W-1:0]        asi_src_sel,
   input  logic [errdp_pkg::SEL_W-1:0]        err_sel,
   input  logic [errdp_pkg::SEL_W-1:0]        misc_sel,
   output logic [errdp_pkg::ASI_W-1:0]        ldxa_data,
   output logic [errdp_pkg::IMASK_W-1:0]      imask
);

   // sized zero fills of the formatted words
   localparam int TAG_PAD_W  = errdp_pkg::ASI_W - errdp_pkg::TAG_RD_W - 3;
   localparam int ICD_PAD_W  = errdp_pkg::ASI_W - errdp_pkg::INST_W;
   localparam int ADDR_PAD_W = errdp_pkg::ASI_W - errdp_pkg::EADDR_W - 4;

   logic [errdp_pkg::ASI_W-1:0] err_word;
   logic [errdp_pkg::ASI_W-1:0] misc_word;
   logic [errdp_pkg::ASI_W-1:0] icd_word;
   logic [errdp_pkg::ASI_W-1:0] ldxa_nxt;

   // ---------------------------------------------------------------------------
   // instruction mask
   // ---------------------------------------------------------------------------
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         imask <= '0;
      end else if (ld_imask) begin
         imask <= asi_wr_data[errdp_pkg::IMASK_W-1:0];
      end
   end

   // ---------------------------------------------------------------------------
   // read word formatting
   // ---------------------------------------------------------------------------
   // error registers
   always_comb begin
      case (err_sel)
         errdp_pkg::ERR_SEL_EN:   err_word = {{(errdp_pkg::ASI_W-errdp_pkg::ERREN_W){1'b0}},
                                              erren_data};
         errdp_pkg::ERR_SEL_STAT: err_word = {32'b0, errstat_data, 9'b0};
         errdp_pkg::ERR_SEL_INJ:  err_word = {32'b0, errinj_data};
         default:                 err_word = {{ADDR_PAD_W{1'b0}}, err_addr_read, 4'b0};
      endcase
   end

   // tag upper nibble sits at 34:31, three zero bits below it
   always_comb begin
      case (misc_sel)
         errdp_pkg::MISC_SEL_TAG:   misc_word = {{TAG_PAD_W{1'b0}},
                                                 tag_asi_data[31:28],
                                                 3'b0,
                                                 tag_asi_data[27:0]};
         errdp_pkg::MISC_SEL_IMASK: misc_word = {{(errdp_pkg::ASI_W-errdp_pkg::IMASK_W){1'b0}},
                                                 imask};
         errdp_pkg::MISC_SEL_ZERO:  misc_word = '0;
         default:                   misc_word = '0;
      endcase
   end

   // parity bit of the cache word moves above the data
   assign icd_word = {{ICD_PAD_W{1'b0}},
                      icd_asi_data[0],
                      icd_asi_data[errdp_pkg::INST_W-1:1]};

   // ---------------------------------------------------------------------------
   // load data
   // ---------------------------------------------------------------------------
   always_comb begin
      case (asi_src_sel)
         errdp_pkg::ASI_SRC_ERR:  ldxa_nxt = err_word;
         errdp_pkg::ASI_SRC_MISC: ldxa_nxt = misc_word;
         errdp_pkg::ASI_SRC_ICD:  ldxa_nxt = icd_word;
         errdp_pkg::ASI_SRC_ZERO: ldxa_nxt = '0;
         default:                 ldxa_nxt = '0;
      endcase
   end

   // one cycle to the LSU
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         ldxa_data <= '0;
      end else begin
         ldxa_data <= ldxa_nxt;
      end
   end

endmodule

//--- source/ifu_errdp.sv
// fetch error datapath top level
// icache parity checks, per-thread error addresses, ASI read path

`timescale 1ns/100ps

module ifu_errdp #(
   parameter int NUM_THREADS = 4
) (
   input  logic                                                     rclk,
   input  logic                                                     arst_n,
   // icache and instruction words
   input  logic [errdp_pkg::IC_WAYS-1:0][errdp_pkg::IC_WAY_W-1:0]  ict_tags,
   input  logic [errdp_pkg::IC_WAYS-1:0]                            icv_valid,
   input  logic [errdp_pkg::INST_W-1:0]                             fetch_data,
   input  logic [errdp_pkg::INST_W-1:0]                             top_data,
   input  logic [errdp_pkg::INST_W-1:0]                             icd_asi_data,
   // error sources
   input  logic [errdp_pkg::EADDR_W-1:0]                            lsu_err_addr,
   input  logic [errdp_pkg::PC_W-1:0]                               fetch_pc,
   input  logic [errdp_pkg::IRF_W-1:0]                              irf_err_reg,
   input  logic [errdp_pkg::IRF_W-1:0]                              irf_err_synd,
   input  logic [errdp_pkg::PC_W-1:0]                               asi_wr_data,
   // selects
   input  logic [NUM_THREADS-1:0][errdp_pkg::EADR_SEL_W-1:0]        eadr_sel,
   input  logic                                                     ld_imask,
   input  logic [errdp_pkg::SEL_W-1:0]                              asi_src_sel,
   input  logic [errdp_pkg::SEL_W-1:0]                              err_sel,
   input  logic [errdp_pkg::SEL_W-1:0]                              misc_sel,
   input  logic [errdp_pkg::SEL_W-1:0]                              asi_thread,
   input  logic [errdp_pkg::SEL_W-1:0]                              asi_way,
   // error control register contents
   input  logic [errdp_pkg::ERREN_W-1:0]                            erren_data,
   input  logic [errdp_pkg::ERRSTAT_W-1:0]                          errstat_data,
   input  logic [errdp_pkg::ERRINJ_W-1:0]                           errinj_data,
   // results
   output logic [errdp_pkg::IC_WAYS-1:0]                            tag_pe,
   output logic                                                     fetch_pe,
   output logic                                                     nir_pe,
   output logic [errdp_pkg::ASI_W-1:0]                              ldxa_data,
   output logic [errdp_pkg::IMASK_W-1:0]                            imask
);

   logic [errdp_pkg::TAG_RD_W-1:0] tag_asi_data;
   logic [errdp_pkg::EADDR_W-1:0]  err_addr_read;

   icache_parity_check u_parity (
      .rclk         (rclk),
      .arst_n       (arst_n),
      .ict_tags     (ict_tags),
      .icv_valid    (icv_valid),
      .fetch_data   (fetch_data),
      .top_data     (top_data),
      .asi_way      (asi_way),
      .tag_pe       (tag_pe),
      .fetch_pe     (fetch_pe),
      .nir_pe       (nir_pe),
      .tag_asi_data (tag_asi_data)
   );

   err_addr_capture #(
      .NUM_THREADS (NUM_THREADS)
   ) u_eadr (
      .rclk          (rclk),
      .arst_n        (arst_n),
      .irf_err_reg   (irf_err_reg),
      .irf_err_synd  (irf_err_synd),
      .lsu_err_addr  (lsu_err_addr),
      .fetch_pc      (fetch_pc),
      .asi_wr_data   (asi_wr_data),
      .eadr_sel      (eadr_sel),
      .asi_thread    (asi_thread),
      .err_addr_read (err_addr_read)
   );

   asi_read_path #(
      .NUM_THREADS (NUM_THREADS)
   ) u_asi (
      .rclk          (rclk),
      .arst_n        (arst_n),
      .asi_wr_data   (asi_wr_data),
      .ld_imask      (ld_imask),
      .erren_data    (erren_data),
      .errstat_data  (errstat_data),
      .errinj_data   (errinj_data),
      .err_addr_read (err_addr_read),
      .tag_asi_data  (tag_asi_data),
      .icd_asi_data  (icd_asi_data),
      .asi_src_sel   (asi_src_sel),
      .err_sel       (err_sel),
      .misc_sel      (misc_sel),
      .ldxa_data     (ldxa_data),
      .imask         (imask)
   );

endmodule

//--- bench/tb_clock.sv
// clock and reset generator for the testbench

`timescale 1ns/100ps

module tb_clock (
   output logic rclk,
   output logic arst_n
);

   // reset held for three clock cycles
   initial begin
      rclk   = 1'b0;
      arst_n = 1'b0;
      repeat (3) @(posedge rclk);
      arst_n <= 1'b1;
   end

   // 100 ns period
   always #50 rclk = ~rclk;

endmodule

//--- bench/ifu_errdp_properties.sv
// concurrent checks on the fetch error datapath, bound into ifu_errdp
// expected outputs are predicted one cycle ahead from the input history

`timescale 1ns/100ps

module ifu_errdp_properties #(
   parameter int NUM_THREADS = 4
) (
   input logic                                                     rclk,
   input logic                                                     arst_n,
   input logic [errdp_pkg::IC_WAYS-1:0][errdp_pkg::IC_WAY_W-1:0]  ict_tags,
   input logic [errdp_pkg::IC_WAYS-1:0]                            icv_valid,
   input logic [errdp_pkg::INST_W-1:0]                             fetch_data,
   input logic [errdp_pkg::INST_W-1:0]                             top_data,
   input logic [errdp_pkg::INST_W-1:0]                             icd_asi_data,
   input logic [errdp_pkg::EADDR_W-1:0]                            lsu_err_addr,
   input logic [errdp_pkg::PC_W-1:0]                               fetch_pc,
   input logic [errdp_pkg::IRF_W-1:0]                              irf_err_reg,
   input logic [errdp_pkg::IRF_W-1:0]                              irf_err_synd,
   input logic [errdp_pkg::PC_W-1:0]                               asi_wr_data,
   input logic [NUM_THREADS-1:0][errdp_pkg::EADR_SEL_W-1:0]        eadr_sel,
   input logic                                                     ld_imask,
   input logic [errdp_pkg::SEL_W-1:0]   asi_src_sel, err_sel, misc_sel, asi_thread, asi_way,
   input logic [errdp_pkg::ERREN_W-1:0]                            erren_data,
   input logic [errdp_pkg::ERRSTAT_W-1:0]                          errstat_data,
   input logic [errdp_pkg::ERRINJ_W-1:0]                           errinj_data,
   input logic [errdp_pkg::IC_WAYS-1:0]                            tag_pe,
   input logic                                                     fetch_pe,
   input logic                                                     nir_pe,
   input logic [errdp_pkg::ASI_W-1:0]                              ldxa_data,
   input logic [errdp_pkg::IMASK_W-1:0]                            imask
);

   int                                                     fails = 0;
   int                                                     live;
   logic [errdp_pkg::IC_WAYS-1:0][errdp_pkg::IC_WAY_W-1:0] tags_h;
   logic [errdp_pkg::IC_WAYS-1:0]                          valid_h;
   logic [errdp_pkg::EADDR_W-1:0]                          lsu_h;
   logic [errdp_pkg::EADDR_W-1:0]                          pc_h1;
   logic [errdp_pkg::EADDR_W-1:0]                          pc_h2;
   logic [errdp_pkg::EADDR_W-1:0]                          irf_h;
   logic [errdp_pkg::EADDR_W-1:0]                          cap_exp [NUM_THREADS];
   logic [NUM_THREADS-1:0]                                 cap_ok;
   logic [errdp_pkg::IC_WAYS-1:0]                          tag_pe_exp;
   logic [errdp_pkg::IMASK_W-1:0]                          imask_m;
   logic [errdp_pkg::ASI_W-1:0]                            ldxa_exp;
   logic                                                   ldxa_chk;

   // IRF record with the register number bit 4 correction
   function automatic logic [errdp_pkg::EADDR_W-1:0] irf_record(input logic [7:0] r,
                                                                input logic [7:0] s);
      errdp_pkg::err_addr_u u;
      u.addr       = '0;
      u.irf.synd   = s;
      u.irf.regnum = {r[7:5], r[4] ^ (r[5] & r[3]), r[3:0]};
      return u.addr;
   endfunction

   // valid, 0, parity, 0 land at 34..31, tag at the bottom
   function automatic logic [63:0] tag_word(input logic [3:0][28:0] tags,
                                            input logic [3:0] v,
                                            input logic [1:0] way);
      logic [28:0] t;
      t = tags[way];
      return {29'b0, v[way], 1'b0, t[28], 1'b0, 3'b0, t[27:0]};
   endfunction

   // ------------------------------------------------------------------------
   // prediction
   // ------------------------------------------------------------------------
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         live    <= 0;
         imask_m <= '0;
      end else begin
         if (live < 15) live <= live + 1;
         if (ld_imask) imask_m <= asi_wr_data[38:0];
      end
   end

   always_ff @(posedge rclk) begin
      tags_h  <= ict_tags;
      valid_h <= icv_valid;
      lsu_h   <= lsu_err_addr;
      pc_h1   <= fetch_pc[47:4];
      pc_h2   <= pc_h1;
      irf_h   <= irf_record(irf_err_reg, irf_err_synd);
      for (int w = 0; w < errdp_pkg::IC_WAYS; w++) tag_pe_exp[w] <= ^ict_tags[w];
      // what each thread register takes at this edge
      for (int t = 0; t < NUM_THREADS; t++) begin
         cap_ok[t] <= eadr_sel[t] != errdp_pkg::EADR_HOLD && live >= 4;
         case (eadr_sel[t])
            errdp_pkg::EADR_IRF: cap_exp[t] <= irf_h;
            errdp_pkg::EADR_LSU: cap_exp[t] <= lsu_h;
            errdp_pkg::EADR_PC:  cap_exp[t] <= pc_h2;
            errdp_pkg::EADR_ASI: cap_exp[t] <= asi_wr_data[47:4];
            default:             cap_exp[t] <= cap_exp[t];
         endcase
      end
      ldxa_chk <= live >= 4;
      case (asi_src_sel)
         errdp_pkg::ASI_SRC_ERR: begin
            case (err_sel)
               errdp_pkg::ERR_SEL_EN:   ldxa_exp <= {62'b0, erren_data};
               errdp_pkg::ERR_SEL_STAT: ldxa_exp <= {32'b0, errstat_data, 9'b0};
               errdp_pkg::ERR_SEL_INJ:  ldxa_exp <= {32'b0, errinj_data};
               default: begin
                  // only known right after a load followed by hold
                  ldxa_exp <= {16'b0, cap_exp[asi_thread], 4'b0};
                  if (!cap_ok[asi_thread] || eadr_sel[asi_thread] != errdp_pkg::EADR_HOLD)
                     ldxa_chk <= 1'b0;
               end
            endcase
         end
         errdp_pkg::ASI_SRC_MISC: begin
            if (misc_sel == errdp_pkg::MISC_SEL_TAG) ldxa_exp <= tag_word(tags_h, valid_h, asi_way);
            else if (misc_sel == errdp_pkg::MISC_SEL_IMASK) ldxa_exp <= {25'b0, imask_m};
            else ldxa_exp <= '0;
         end
         errdp_pkg::ASI_SRC_ICD: ldxa_exp <= {30'b0, icd_asi_data[0], icd_asi_data[33:1]};
         default:                ldxa_exp <= '0;
      endcase
   end

   // ------------------------------------------------------------------------
   // assertions
   // ------------------------------------------------------------------------
   a_reset: assert property (@(posedge rclk) disable iff (!arst_n)
         live == 0 |-> imask == '0 && ldxa_data == '0)
      else begin
         fails++;
         $error("Error imask %h ldxa_data %h after reset", $sampled(imask), $sampled(ldxa_data));
      end

   a_tag_pe: assert property (@(posedge rclk) disable iff (!arst_n)
         live >= 2 |-> tag_pe == tag_pe_exp)
      else begin
         fails++;
         $error("Error tag_pe %h expected %h", $sampled(tag_pe), $sampled(tag_pe_exp));
      end

   a_inst_pe: assert property (@(posedge rclk) disable iff (!arst_n)
         fetch_pe == ^fetch_data && nir_pe == ^top_data)
      else begin
         fails++;
         $error("Error fetch_pe %h nir_pe %h expected %h %h", $sampled(fetch_pe),
                $sampled(nir_pe), $sampled(^fetch_data), $sampled(^top_data));
      end

   a_imask: assert property (@(posedge rclk) disable iff (!arst_n)
         imask == imask_m)
      else begin
         fails++;
         $error("Error imask %h expected %h", $sampled(imask), $sampled(imask_m));
      end

   a_ldxa: assert property (@(posedge rclk) disable iff (!arst_n)
         ldxa_chk |-> ldxa_data == ldxa_exp)
      else begin
         fails++;
         $error("Error ldxa_data %h expected %h", $sampled(ldxa_data), $sampled(ldxa_exp));
      end

endmodule

//--- bench/ifu_errdp_tb.sv
// top testbench for the fetch error datapath
// random stimulus with biased selects, checking done by the bound properties

`timescale 1ns/100ps

module ifu_errdp_tb;

   localparam int NUM_THREADS = 4;
   localparam int NUM_CYCLES  = 3000;

   logic                                                     rclk;
   logic                                                     arst_n;
   logic [errdp_pkg::IC_WAYS-1:0][errdp_pkg::IC_WAY_W-1:0]  ict_tags;
   logic [errdp_pkg::IC_WAYS-1:0]                            icv_valid;
   logic [errdp_pkg::INST_W-1:0]                             fetch_data;
   logic [errdp_pkg::INST_W-1:0]                             top_data;
   logic [errdp_pkg::INST_W-1:0]                             icd_asi_data;
   logic [errdp_pkg::EADDR_W-1:0]                            lsu_err_addr;
   logic [errdp_pkg::PC_W-1:0]                               fetch_pc;
   logic [errdp_pkg::IRF_W-1:0]                              irf_err_reg;
   logic [errdp_pkg::IRF_W-1:0]                              irf_err_synd;
   logic [errdp_pkg::PC_W-1:0]                               asi_wr_data;
   logic [NUM_THREADS-1:0][errdp_pkg::EADR_SEL_W-1:0]        eadr_sel;
   logic                                                     ld_imask;
   logic [errdp_pkg::SEL_W-1:0]   asi_src_sel, err_sel, misc_sel, asi_thread, asi_way;
   logic [errdp_pkg::ERREN_W-1:0]                            erren_data;
   logic [errdp_pkg::ERRSTAT_W-1:0]                          errstat_data;
   logic [errdp_pkg::ERRINJ_W-1:0]                           errinj_data;
   logic [errdp_pkg::IC_WAYS-1:0]                            tag_pe;
   logic                                                     fetch_pe;
   logic                                                     nir_pe;
   logic [errdp_pkg::ASI_W-1:0]                              ldxa_data;
   logic [errdp_pkg::IMASK_W-1:0]                            imask;
   int                                                       timeouts;

   tb_clock u_clk (
      .rclk   (rclk),
      .arst_n (arst_n)
   );

   ifu_errdp #(
      .NUM_THREADS (NUM_THREADS)
   ) UUT (.*);

   bind ifu_errdp ifu_errdp_properties #(.NUM_THREADS(NUM_THREADS)) u_props (.*);

   function automatic logic [63:0] rand64();
      return {$urandom, $urandom};
   endfunction

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (!arst_n && n < 20) begin
         @(posedge rclk);
         n++;
      end
      if (!arst_n) begin
         timeouts++;
         $display("reset was never released");
      end
   endtask

   task automatic drive_cycle(input int cyc);
      logic [errdp_pkg::IC_WAYS-1:0][errdp_pkg::IC_WAY_W-1:0] tags;
      logic [63:0]                                            r;
      @(posedge rclk);
      for (int w = 0; w < errdp_pkg::IC_WAYS; w++) begin
         r       = rand64();
         tags[w] = r[28:0];
         // about a quarter of the ways get clean parity
         if (r[40:39] == 2'b00) tags[w][28] = ^r[27:0];
      end
      ict_tags     <= tags;
      icv_valid    <= 4'(rand64());
      fetch_data   <= 34'(rand64());
      top_data     <= 34'(rand64());
      icd_asi_data <= 34'(rand64());
      lsu_err_addr <= 44'(rand64());
      fetch_pc     <= 48'(rand64());
      irf_err_reg  <= 8'(rand64());
      irf_err_synd <= 8'(rand64());
      asi_wr_data  <= 48'(rand64());
      erren_data   <= 2'(rand64());
      errstat_data <= 23'(rand64());
      errinj_data  <= 32'(rand64());
      ld_imask     <= ($urandom_range(3, 0) == 0);
      asi_src_sel  <= 2'(rand64());
      err_sel      <= 2'(rand64());
      misc_sel     <= 2'($urandom_range(2, 0));
      asi_thread   <= 2'(rand64());
      asi_way      <= 2'(rand64());
      // loads every third cycle, holds in between so a read sees the new address
      for (int t = 0; t < NUM_THREADS; t++) begin
         eadr_sel[t] <= (cyc % 3 == 0) ? 3'($urandom_range(4, 1)) : errdp_pkg::EADR_HOLD;
      end
   endtask

   initial begin
      int errors;
      void'($urandom(91));
      timeouts     = 0;
      ict_tags     = '0;
      icv_valid    = '0;
      fetch_data   = '0;
      top_data     = '0;
      icd_asi_data = '0;
      lsu_err_addr = '0;
      fetch_pc     = '0;
      irf_err_reg  = '0;
      irf_err_synd = '0;
      eadr_sel     = '0;
      asi_src_sel  = '0;
      err_sel      = '0;
      misc_sel     = '0;
      asi_thread   = '0;
      asi_way      = '0;
      errstat_data = '0;
      errinj_data  = '0;
      // mask load and a nonzero enable word pending while reset is held
      asi_wr_data  = 48'h5a5a_c3c3_f0f1;
      ld_imask     = 1'b1;
      erren_data   = 2'b11;

      wait_reset_release();
      for (int c = 0; c < NUM_CYCLES; c++) begin
         drive_cycle(c);
      end
      // drain the two-stage read pipeline
      repeat (4) @(posedge rclk);

      errors = UUT.u_props.fails;
      $display("assertion failures %0d, timeouts %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- ifu_errdp.f
source/errdp_pkg.sv
source/icache_parity_check.sv
source/err_addr_capture.sv
source/asi_read_path.sv
source/ifu_errdp.sv
bench/tb_clock.sv
bench/ifu_errdp_properties.sv
bench/ifu_errdp_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the ifu_errdp testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module ifu_errdp_tb \
   -f ifu_errdp.f

# the error limit keeps the run going past the first failing assertion
./obj_dir/Vifu_errdp_tb +verilator+error+limit+100000 \
   | tee /dev/stderr \
   | grep -qx "Regression passed"
